/* verilog/hog_norm_pkg.sv */
// HOG block normalization definitions
package hog_norm_pkg;

	// ------------------------------
	// widths and fixed-point formats
	// ------------------------------
	localparam int SOS_W = 35;                      // energy / norm / bin word
	localparam int QN    = 8;                       // frac bits of energies and norms
	localparam int YF    = 12;                      // frac bits of the rsqrt estimate

	localparam logic [31:0] MAGIC_NUM = 32'h5f37_59df; // fast rsqrt seed constant

	typedef logic [SOS_W-1:0]   sos_t;              // energy, norm or bin
	typedef logic [2*SOS_W-1:0] prod_t;             // full product
	typedef logic [QN-1:0]      feature_t;          // output feature

	localparam sos_t TRUNC_LIMIT = 35'd51;          // 0.2 in Q8

	// block order inside one 3x3 window
	typedef enum logic [2:0] {
		BLOCK_IDLE,                                 // waiting for a window
		BLOCK_RD,                                   // cells 1,2,4,5
		BLOCK_RU,                                   // cells 4,5,7,8
		BLOCK_LD,                                   // cells 2,3,5,6
		BLOCK_LU                                    // cells 5,6,8,9
	} block_e;

endpackage

/* verilog/block_energy_sum.sv */
// Block energy sequencer
`timescale 1ns/100ps

module block_energy_sum (
	input  logic                aclk,
	input  logic                reset,
	input  logic                window_valid,       // one pulse per cell
	input  hog_norm_pkg::sos_t  sos_1,
	input  hog_norm_pkg::sos_t  sos_2,
	input  hog_norm_pkg::sos_t  sos_3,
	input  hog_norm_pkg::sos_t  sos_4,
	input  hog_norm_pkg::sos_t  sos_5,              // centre cell
	input  hog_norm_pkg::sos_t  sos_6,
	input  hog_norm_pkg::sos_t  sos_7,
	input  hog_norm_pkg::sos_t  sos_8,
	input  hog_norm_pkg::sos_t  sos_9,
	output logic                block_valid,
	output hog_norm_pkg::sos_t  block_sos           // four-cell sum plus epsilon
);

	hog_norm_pkg::block_e state, state_nxt;
	hog_norm_pkg::sos_t   quad_sum;

	always_ff @(posedge aclk) begin
		if (reset) begin
			state <= hog_norm_pkg::BLOCK_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;                          // hold by default
		case (state)
			hog_norm_pkg::BLOCK_IDLE: begin
				if (window_valid) begin
					state_nxt = hog_norm_pkg::BLOCK_RD;
				end
			end
			hog_norm_pkg::BLOCK_RD: state_nxt = hog_norm_pkg::BLOCK_RU;
			hog_norm_pkg::BLOCK_RU: state_nxt = hog_norm_pkg::BLOCK_LD;
			hog_norm_pkg::BLOCK_LD: state_nxt = hog_norm_pkg::BLOCK_LU;
			default:                state_nxt = hog_norm_pkg::BLOCK_IDLE;
		endcase
	end

	// sum picked by the state being entered, so data lines up with valid
	always_comb begin
		case (state_nxt)
			hog_norm_pkg::BLOCK_RD: quad_sum = sos_1 + sos_2 + sos_4 + sos_5 + 35'd1;
			hog_norm_pkg::BLOCK_RU: quad_sum = sos_4 + sos_5 + sos_7 + sos_8 + 35'd1;
			hog_norm_pkg::BLOCK_LD: quad_sum = sos_2 + sos_3 + sos_5 + sos_6 + 35'd1;
			hog_norm_pkg::BLOCK_LU: quad_sum = sos_5 + sos_6 + sos_8 + sos_9 + 35'd1;
			default:                quad_sum = '0;
		endcase
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			block_valid <= 1'b0;
		end else begin
			block_valid <= (state_nxt != hog_norm_pkg::BLOCK_IDLE); // four cycles high
		end
		block_sos <= quad_sum;                      // +1 is one Q8 lsb
	end

	// a new window only while the previous four blocks are done
	a_window_idle: assert property (@(posedge aclk) disable iff (reset)
		window_valid |-> state == hog_norm_pkg::BLOCK_IDLE);

endmodule

/* verilog/inv_sqrt_fast.sv */
// Fast inverse square root pipeline
`timescale 1ns/100ps

module inv_sqrt_fast (
	input  logic                aclk,
	input  logic                reset,
	input  logic                block_valid,
	input  hog_norm_pkg::sos_t  block_sos,          // r in Q8
	output logic                norm_valid,
	output hog_norm_pkg::sos_t  norm                // 1/sqrt(r) in Q8
);

	localparam int FIX_BIAS = 127 + 23 - hog_norm_pkg::YF;   // float exp to YF fixed
	localparam int FIN_SH   = 2*hog_norm_pkg::YF + 1 - hog_norm_pkg::QN;
	localparam hog_norm_pkg::sos_t THREE = 35'd3 << hog_norm_pkg::YF;

	logic [6:0]          vld_sr;                    // one bit per stage
	logic [5:0]          msb_pos;
	hog_norm_pkg::sos_t  r_norm;
	logic [31:0]         f_pack;
	logic [7:0]          y_exp;
	logic [23:0]         y_man;
	hog_norm_pkg::sos_t  y_fix;
	hog_norm_pkg::prod_t sq_full, yyr_full, fin_full;

	logic [31:0]         f_s1, yf_s2;
	hog_norm_pkg::sos_t  r_s1, r_s2, r_s3, r_s4;
	hog_norm_pkg::sos_t  y_s3, y_s4, y_s5, y_s6;
	hog_norm_pkg::sos_t  y2_s4, d_s6;
	hog_norm_pkg::prod_t t_s5;

	// ------------------------------
	// stage 1: fixed to float
	// ------------------------------
	always_comb begin
		msb_pos = '0;
		for (int i = 0; i < hog_norm_pkg::SOS_W; i++) begin
			if (block_sos[i]) begin
				msb_pos = 6'(i);                    // last hit is the top one
			end
		end
		r_norm = block_sos << (hog_norm_pkg::SOS_W - 1 - int'(msb_pos)); // msb to bit 34
		f_pack = {1'b0, 8'(int'(msb_pos) + 127 - hog_norm_pkg::QN),
			r_norm[hog_norm_pkg::SOS_W-2 -: 23]};   // mantissa truncated
	end

	// ------------------------------
	// stage 3: float to YF fixed
	// ------------------------------
	always_comb begin
		y_exp = yf_s2[30:23];
		y_man = {1'b1, yf_s2[22:0]};                // hidden one back in
		if (int'(y_exp) >= FIX_BIAS) begin
			y_fix = hog_norm_pkg::sos_t'(y_man) << (int'(y_exp) - FIX_BIAS);
		end else begin
			y_fix = hog_norm_pkg::sos_t'(y_man) >> (FIX_BIAS - int'(y_exp)); // toward zero
		end
	end

	// newton products, full width
	assign sq_full  = hog_norm_pkg::prod_t'(y_s3) * hog_norm_pkg::prod_t'(y_s3);
	assign yyr_full = hog_norm_pkg::prod_t'(y2_s4) * hog_norm_pkg::prod_t'(r_s4);
	assign fin_full = hog_norm_pkg::prod_t'(y_s6) * hog_norm_pkg::prod_t'(d_s6);

	always_ff @(posedge aclk) begin
		if (reset) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[5:0], block_valid};
		end
		f_s1  <= f_pack;                            // s1
		r_s1  <= block_sos;
		yf_s2 <= hog_norm_pkg::MAGIC_NUM - (f_s1 >> 1); // s2 magic estimate
		r_s2  <= r_s1;
		y_s3  <= y_fix;                             // s3
		r_s3  <= r_s2;
		y2_s4 <= sq_full[hog_norm_pkg::SOS_W+hog_norm_pkg::YF-1:hog_norm_pkg::YF]; // s4 y*y
		y_s4  <= y_s3;
		r_s4  <= r_s3;
		t_s5  <= yyr_full >> hog_norm_pkg::QN;      // s5 y*y*r, YF frac
		y_s5  <= y_s4;
		if (t_s5 > hog_norm_pkg::prod_t'(THREE)) begin // s6, clamp at zero
			d_s6 <= '0;
		end else begin
			d_s6 <= THREE - hog_norm_pkg::sos_t'(t_s5);
		end
		y_s6  <= y_s5;
		norm  <= fin_full[hog_norm_pkg::SOS_W+FIN_SH-1:FIN_SH]; // s7 halve and back to Q8
	end

	assign norm_valid = vld_sr[6];                  // seven cycles after block_valid

endmodule

/* verilog/norm_store.sv */
// Inverse norm store
`timescale 1ns/100ps

module norm_store (
	input  logic                aclk,
	input  logic                reset,
	input  logic                norm_valid,
	input  hog_norm_pkg::sos_t  norm,
	output logic                norm_ready,         // pulses once all four norms are held
	output hog_norm_pkg::sos_t  norm_rd,
	output hog_norm_pkg::sos_t  norm_ru,
	output hog_norm_pkg::sos_t  norm_ld,
	output hog_norm_pkg::sos_t  norm_lu
);

	logic [1:0] arr_cnt;                            // norms seen in this cell

	always_ff @(posedge aclk) begin
		if (reset) begin
			arr_cnt    <= 2'd0;
			norm_ready <= 1'b0;
		end else begin
			norm_ready <= norm_valid && (arr_cnt == 2'd3); // fourth one lands
			if (norm_valid) begin
				arr_cnt <= arr_cnt + 2'd1;          // wraps each cell
			end
		end
	end

	// arrival order rd, ru, ld, lu so rd ends at the far end
	always_ff @(posedge aclk) begin
		if (norm_valid) begin
			norm_lu <= norm;
			norm_ld <= norm_lu;
			norm_ru <= norm_ld;
			norm_rd <= norm_ru;
		end
	end

	// norms of a cell arrive as one run of four
	a_cell_aligned: assert property (@(posedge aclk) disable iff (reset)
		$rose(norm_valid) |-> arr_cnt == 2'd0);

endmodule

/* verilog/bin_pca_reduce.sv */
// Bin normalization and PCA reduction
`timescale 1ns/100ps

module bin_pca_reduce #(
	parameter hog_norm_pkg::sos_t TRUNC_LIMIT = hog_norm_pkg::TRUNC_LIMIT
) (
	input  logic                    aclk,
	input  logic                    reset,
	input  logic                    bin_valid,
	input  hog_norm_pkg::sos_t      bin_data,       // order 0,9,1,10,...,8,17
	input  hog_norm_pkg::sos_t      norm_rd,
	input  hog_norm_pkg::sos_t      norm_ru,
	input  hog_norm_pkg::sos_t      norm_ld,
	input  hog_norm_pkg::sos_t      norm_lu,
	output logic                    bin0_17_valid,
	output hog_norm_pkg::feature_t  bin0_17,        // signed-bin feature
	output logic                    bin18_26_valid,
	output hog_norm_pkg::feature_t  bin18_26        // unsigned-bin feature
);

	typedef logic [hog_norm_pkg::QN+1:0] acc_t;     // room for four clamped terms

	hog_norm_pkg::sos_t     nrm [4];
	hog_norm_pkg::sos_t     bin_prev;               // first bin of the pair
	hog_norm_pkg::sos_t     pair_sum;
	logic                   pair_odd;               // 1 on the second bin of a pair
	hog_norm_pkg::feature_t sgn_clip [4];
	hog_norm_pkg::feature_t uns_clip [4];
	logic                   sgn_v1, uns_v1;
	acc_t                   sgn_sum, uns_sum;

	// normalize by one norm, then clamp at the limit
	function automatic hog_norm_pkg::feature_t clip_norm(input hog_norm_pkg::sos_t val,
		input hog_norm_pkg::sos_t nv);
		hog_norm_pkg::prod_t p;
		p = (hog_norm_pkg::prod_t'(val) * hog_norm_pkg::prod_t'(nv)) >> hog_norm_pkg::QN;
		if (p < hog_norm_pkg::prod_t'(TRUNC_LIMIT)) begin
			return hog_norm_pkg::feature_t'(p);
		end
		return hog_norm_pkg::feature_t'(TRUNC_LIMIT);
	endfunction

	assign nrm[0]   = norm_rd;
	assign nrm[1]   = norm_ru;
	assign nrm[2]   = norm_ld;
	assign nrm[3]   = norm_lu;
	assign pair_sum = bin_data + bin_prev;          // bin k plus bin k+9

	// ------------------------------
	// stage 1 eight clamped products
	// ------------------------------
	always_ff @(posedge aclk) begin
		if (reset) begin
			pair_odd <= 1'b0;
			sgn_v1   <= 1'b0;
			uns_v1   <= 1'b0;
		end else begin
			sgn_v1 <= bin_valid;
			uns_v1 <= bin_valid && pair_odd;        // pair complete
			if (bin_valid) begin
				pair_odd <= ~pair_odd;
			end
		end
		if (bin_valid) begin
			bin_prev <= bin_data;
		end
		for (int k = 0; k < 4; k++) begin
			sgn_clip[k] <= clip_norm(bin_data, nrm[k]);
			uns_clip[k] <= clip_norm(pair_sum, nrm[k]);
		end
	end

	always_comb begin
		sgn_sum = '0;
		uns_sum = '0;
		for (int k = 0; k < 4; k++) begin
			sgn_sum = sgn_sum + acc_t'(sgn_clip[k]);
			uns_sum = uns_sum + acc_t'(uns_clip[k]);
		end
	end

	// ------------------------------
	// stage 2 halved sums out
	// ------------------------------
	always_ff @(posedge aclk) begin
		if (reset) begin
			bin0_17_valid  <= 1'b0;
			bin18_26_valid <= 1'b0;
		end else begin
			bin0_17_valid  <= sgn_v1;               // two cycles after the bin
			bin18_26_valid <= uns_v1;
		end
		bin0_17  <= sgn_sum[hog_norm_pkg::QN:1];    // sum >> 1
		bin18_26 <= uns_sum[hog_norm_pkg::QN:1];
	end

	// pair sum of bin k and bin k+9 fits the word
	a_pair_no_wrap: assert property (@(posedge aclk) disable iff (reset)
		bin_valid && pair_odd |-> pair_sum >= bin_data);

endmodule

/* verilog/hog_norm_top.sv */
// HOG block normalization top
`timescale 1ns/100ps

module hog_norm_top #(
	parameter hog_norm_pkg::sos_t TRUNC_LIMIT = hog_norm_pkg::TRUNC_LIMIT
) (
	input  logic                    aclk,
	input  logic                    reset,
	input  logic                    window_valid,
	input  hog_norm_pkg::sos_t      sos_1,
	input  hog_norm_pkg::sos_t      sos_2,
	input  hog_norm_pkg::sos_t      sos_3,
	input  hog_norm_pkg::sos_t      sos_4,
	input  hog_norm_pkg::sos_t      sos_5,
	input  hog_norm_pkg::sos_t      sos_6,
	input  hog_norm_pkg::sos_t      sos_7,
	input  hog_norm_pkg::sos_t      sos_8,
	input  hog_norm_pkg::sos_t      sos_9,
	input  logic                    bin_valid,
	input  hog_norm_pkg::sos_t      bin_data,
	output logic                    norm_ready,     // 12 cycles after window_valid
	output logic                    bin0_17_valid,
	output hog_norm_pkg::feature_t  bin0_17,
	output logic                    bin18_26_valid,
	output hog_norm_pkg::feature_t  bin18_26
);

	logic               block_valid, norm_valid;
	hog_norm_pkg::sos_t block_sos, norm;
	hog_norm_pkg::sos_t norm_rd, norm_ru, norm_ld, norm_lu;

	block_energy_sum block_energy_sum_i (
		.aclk, .reset, .window_valid,
		.sos_1, .sos_2, .sos_3, .sos_4, .sos_5, .sos_6, .sos_7, .sos_8, .sos_9,
		.block_valid, .block_sos
	);

	inv_sqrt_fast inv_sqrt_fast_i (             // 7-cycle latency
		.aclk, .reset, .block_valid, .block_sos,
		.norm_valid, .norm
	);

	norm_store norm_store_i (
		.aclk, .reset, .norm_valid, .norm,
		.norm_ready, .norm_rd, .norm_ru, .norm_ld, .norm_lu
	);

	bin_pca_reduce #(.TRUNC_LIMIT(TRUNC_LIMIT)) bin_pca_reduce_i (
		.aclk, .reset, .bin_valid, .bin_data,
		.norm_rd, .norm_ru, .norm_ld, .norm_lu,
		.bin0_17_valid, .bin0_17, .bin18_26_valid, .bin18_26
	);

endmodule

/* test/hog_norm_tb.sv */
// HOG normalization testbench
`timescale 1ns/100ps

module hog_norm_tb;

	typedef longint unsigned u64_t;
	localparam int NUM_CELLS = 14;                  // random, clamp, min, gaps, ten in a row
	localparam int TIMEOUT   = 80 * NUM_CELLS + 100;

	logic aclk = 1'b0;
	logic reset, window_valid, bin_valid;
	hog_norm_pkg::sos_t sos_1, sos_2, sos_3, sos_4, sos_5, sos_6, sos_7, sos_8, sos_9;
	hog_norm_pkg::sos_t bin_data;
	logic norm_ready, bin0_17_valid, bin18_26_valid;
	hog_norm_pkg::feature_t bin0_17, bin18_26;

	integer seed = 32'h34b461b3;
	int cyc = 0;                                    // edges since start
	hog_norm_pkg::sos_t cell_sos [9];               // row-major 3x3 energies
	hog_norm_pkg::sos_t cell_bins [18];             // indexed by bin number
	logic cell_done = 1'b0;                         // last feature of the cell checked
	int cells_checked = 0;
	logic sat_cell = 1'b0;                          // every clamp expected to hit

	logic window_seen = 1'b0;
	logic ready_seen;
	int win_cyc, bin_pos, sgn_cnt, uns_cnt;
	u64_t exp_norm [4];                             // rd, ru, ld, lu
	u64_t bin_prev;
	int sgn_val_q[$], sgn_due_q[$], uns_val_q[$], uns_due_q[$];

	hog_norm_top hog_norm_top_i (.*);

	always #2 aclk = ~aclk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name,
				got, exp));
		end
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic u64_t inv_sqrt_model(input u64_t r);
		int msb;
		int ex;
		int sh;
		u64_t mant, fbits, ybits, y, y2, t, d, three;
		msb = 0;
		for (int i = 0; i < 64; i++) begin
			if (r[i]) msb = i;                      // top set bit
		end
		ex = msb - hog_norm_pkg::QN + 127;
		if (msb >= 23) mant = (r >> (msb - 23)) & 64'h7f_ffff;
		else mant = (r << (23 - msb)) & 64'h7f_ffff;   // zero-filled
		fbits = (u64_t'(ex) << 23) | mant;
		ybits = (u64_t'(hog_norm_pkg::MAGIC_NUM) - (fbits >> 1)) & 64'hffff_ffff;
		mant  = (ybits & 64'h7f_ffff) | 64'h80_0000;    // hidden one
		sh    = int'((ybits >> 23) & 64'hff) - 150 + hog_norm_pkg::YF;
		if (sh >= 0) y = mant << sh;
		else y = mant >> (-sh);                     // truncates toward zero
		y2    = (y * y) >> hog_norm_pkg::YF;
		t     = (y2 * r) >> hog_norm_pkg::QN;
		three = 64'd3 << hog_norm_pkg::YF;
		d     = (t > three) ? 64'd0 : three - t;
		return (y * d) >> (2 * hog_norm_pkg::YF + 1 - hog_norm_pkg::QN);
	endfunction

	function automatic int pca_feature(input u64_t v, input u64_t n0, input u64_t n1,
		input u64_t n2, input u64_t n3);
		u64_t nv [4];
		u64_t p;
		u64_t lim;
		int acc;
		nv  = '{n0, n1, n2, n3};
		lim = u64_t'(hog_norm_pkg::TRUNC_LIMIT);
		acc = 0;
		for (int k = 0; k < 4; k++) begin
			p = (v * nv[k]) >> hog_norm_pkg::QN;
			acc += (p < lim) ? int'(p) : int'(lim); // clamp at 0.2
		end
		return acc >> 1;
	endfunction

	always @(posedge aclk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT) begin
			abort_run($sformatf("timeout, run still going after %0d cycles", cyc));
		end
	end

	// ------------------------------
	// monitor and compare
	// ------------------------------
	always @(posedge aclk) begin
		if (cyc > 0 && !window_seen) begin          // quiet outputs before the first cell
			check("norm_ready", norm_ready, 0);
			check("bin0_17_valid", bin0_17_valid, 0);
			check("bin18_26_valid", bin18_26_valid, 0);
		end
		if (!reset) begin
			if (window_valid) begin
				window_seen = 1'b1;
				win_cyc     = cyc;
				ready_seen  = 1'b0;
				bin_pos     = 0;
				sgn_cnt     = 0;
				uns_cnt     = 0;
				exp_norm[0] = inv_sqrt_model(u64_t'(sos_1) + u64_t'(sos_2) + u64_t'(sos_4) +
					u64_t'(sos_5) + 64'd1);
				exp_norm[1] = inv_sqrt_model(u64_t'(sos_4) + u64_t'(sos_5) + u64_t'(sos_7) +
					u64_t'(sos_8) + 64'd1);
				exp_norm[2] = inv_sqrt_model(u64_t'(sos_2) + u64_t'(sos_3) + u64_t'(sos_5) +
					u64_t'(sos_6) + 64'd1);
				exp_norm[3] = inv_sqrt_model(u64_t'(sos_5) + u64_t'(sos_6) + u64_t'(sos_8) +
					u64_t'(sos_9) + 64'd1);
				cell_done <= 1'b0;
			end
			if (norm_ready) begin
				if (ready_seen) abort_run("norm_ready pulsed twice in one cell");
				else check("norm_ready latency", cyc - win_cyc, 12);
				ready_seen = 1'b1;
			end
			if (bin18_26_valid) begin
				if (uns_val_q.size() == 0) begin
					abort_run("unsigned feature with no bin pair pending");
				end else begin
					check("bin18_26", bin18_26, uns_val_q.pop_front());
					check("bin18_26 cycle", cyc, uns_due_q.pop_front());
					if (sat_cell) check("bin18_26 saturated", bin18_26, 102);
					uns_cnt++;
				end
			end
			if (bin0_17_valid) begin
				if (sgn_val_q.size() == 0) begin
					abort_run("signed feature with no bin pending");
				end else begin
					check("bin0_17", bin0_17, sgn_val_q.pop_front());
					check("bin0_17 cycle", cyc, sgn_due_q.pop_front());
					if (sat_cell) check("bin0_17 saturated", bin0_17, 102);
					sgn_cnt++;
					if (sgn_cnt == 18) begin    // cell complete
						check("bin18_26 count", uns_cnt, 9);
						cell_done     <= 1'b1;
						cells_checked <= cells_checked + 1;
					end
				end
			end
			if (bin_valid) begin
				sgn_val_q.push_back(pca_feature(u64_t'(bin_data), exp_norm[0], exp_norm[1],
					exp_norm[2], exp_norm[3]));
				sgn_due_q.push_back(cyc + 2);
				if (bin_pos % 2 == 1) begin     // second bin of the pair
					uns_val_q.push_back(pca_feature(u64_t'(bin_data) + bin_prev, exp_norm[0],
						exp_norm[1], exp_norm[2], exp_norm[3]));
					uns_due_q.push_back(cyc + 2);
				end
				bin_prev = u64_t'(bin_data);
				bin_pos++;
			end
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	task automatic fill_random(input logic [31:0] sos_mask, input logic [31:0] bin_mask);
		for (int i = 0; i < 9; i++) begin
			cell_sos[i] = hog_norm_pkg::sos_t'($unsigned($random(seed)) & sos_mask);
		end
		for (int i = 0; i < 18; i++) begin
			cell_bins[i] = hog_norm_pkg::sos_t'($unsigned($random(seed)) & bin_mask);
		end
	endtask

	task automatic run_cell(input int max_gap);
		int gap;
		int idx;
		{sos_1, sos_2, sos_3} <= {cell_sos[0], cell_sos[1], cell_sos[2]};
		{sos_4, sos_5, sos_6} <= {cell_sos[3], cell_sos[4], cell_sos[5]};
		{sos_7, sos_8, sos_9} <= {cell_sos[6], cell_sos[7], cell_sos[8]};
		window_valid <= 1'b1;
		@(posedge aclk);
		window_valid <= 1'b0;
		do @(posedge aclk); while (norm_ready !== 1'b1);
		for (int p = 0; p < 18; p++) begin
			idx = (p % 2 == 0) ? p / 2 : p / 2 + 9; // order 0,9,1,10,...
			gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
			if (gap > 0) begin
				bin_valid <= 1'b0;
				repeat (gap) @(posedge aclk);
			end
			bin_valid <= 1'b1;
			bin_data  <= cell_bins[idx];
			@(posedge aclk);
		end
		bin_valid <= 1'b0;
		do @(posedge aclk); while (!cell_done);     // last feature of the cell
	endtask

	initial begin
		reset = 1'b1;
		window_valid = 1'b0;
		bin_valid = 1'b0;
		bin_data = '0;
		{sos_1, sos_2, sos_3, sos_4, sos_5, sos_6, sos_7, sos_8, sos_9} = '0;
		repeat (3) @(posedge aclk);
		reset <= 1'b0;
		repeat (2) @(posedge aclk);
		fill_random(32'h000f_ffff, 32'h0000_3fff);  // random cell
		run_cell(0);
		fill_random(32'h0000_00ff, 32'h0000_ffff);  // small energies, huge bins
		for (int i = 0; i < 18; i++) cell_bins[i] = cell_bins[i] + 35'h1000_0000;
		sat_cell <= 1'b1;
		run_cell(0);
		sat_cell <= 1'b0;
		fill_random(32'h0, 32'h3);                  // r of one lsb, largest norm
		run_cell(0);
		fill_random(32'h000f_ffff, 32'h0000_3fff);  // idle gaps between bins
		run_cell(2);
		repeat (10) begin
			fill_random(32'h000f_ffff, 32'h0000_3fff);
			run_cell(0);
		end
		if (cells_checked == NUM_CELLS && sgn_val_q.size() == 0 && uns_val_q.size() == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			abort_run($sformatf("only %0d of %0d cells completed", cells_checked, NUM_CELLS));
		end
	end

endmodule

/* build.f */
verilog/hog_norm_pkg.sv
verilog/block_energy_sum.sv
verilog/inv_sqrt_fast.sv
verilog/norm_store.sv
verilog/bin_pca_reduce.sv
verilog/hog_norm_top.sv
test/hog_norm_tb.sv

/* Makefile */
TOP = hog_norm_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir
